// ==== all.f ====
+incdir+verilog
verilog/rbcp_bus_pkg.sv
verilog/rbcp_bridge_pkg.sv
verilog/rbcp_bridge_fsm.sv
verilog/bus_latency_timer.sv
verilog/gpio_regs.sv
verilog/scratch_regs.sv
verilog/rbcp_bus_top.sv
dv/tb_rbcp_bus.sv

// ==== Bender.yml ====
package:
  name: rbcp_bus

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rbcp_bus_pkg.sv
      - verilog/rbcp_bridge_pkg.sv
      - verilog/rbcp_bridge_fsm.sv
      - verilog/bus_latency_timer.sv
      - verilog/gpio_regs.sv
      - verilog/scratch_regs.sv
      - verilog/rbcp_bus_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/tb_rbcp_bus.sv

// ==== dv/tb_rbcp_bus.sv ====
`timescale 1ns/1ps
`include "rbcp_macros.svh"

module tb_rbcp_bus;
    import rbcp_bus_pkg::*;

    localparam int NUM_RANDOM     = 400;
    localparam int TIMEOUT_CYCLES = NUM_RANDOM * 6 + 100;    // slowest access plus slack

    typedef struct {
        bus_op_e    op;
        bus_addr_t  addr;
        bus_data_t  data;
        logic [7:0] pins;   // gpio_in held through the access
    } txn_t;

    logic       bus_clk;
    logic       rst_n;
    logic       rbcp_act;
    bus_addr_t  rbcp_addr;
    bus_data_t  rbcp_wd;
    logic       rbcp_we;
    logic       rbcp_re;
    logic [7:0] gpio_in;
    logic       rbcp_ack;
    bus_data_t  rbcp_rd;
    logic [7:0] gpio_out;
    logic [7:0] gpio_oe;

    bus_data_t  model_out;              // gpio offset 2
    bus_data_t  model_dir;              // gpio offset 3
    bus_data_t  model_scratch [16];
    int         cycle_cnt = 0;

    rbcp_bus_top dut (
        .bus_clk   (bus_clk),
        .rst_n     (rst_n),
        .rbcp_act  (rbcp_act),
        .rbcp_addr (rbcp_addr),
        .rbcp_wd   (rbcp_wd),
        .rbcp_we   (rbcp_we),
        .rbcp_re   (rbcp_re),
        .gpio_in   (gpio_in),
        .rbcp_ack  (rbcp_ack),
        .rbcp_rd   (rbcp_rd),
        .gpio_out  (gpio_out),
        .gpio_oe   (gpio_oe)
    );

    always #5 bus_clk = ~bus_clk;       // 100 MHz bus clock

    always @(posedge bus_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES));
        end
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_rd(input bus_addr_t addr, input bus_data_t exp, input bus_data_t got);
        if (got !== exp) begin
            fail_run($sformatf("ERROR rbcp_rd addr 0x%08h: expected 0x%02h got 0x%02h",
                               addr, exp, got));
        end
    endtask

    task automatic check_gpio(input bus_data_t exp_out, input bus_data_t exp_oe);
        if (bus_data_t'(gpio_out) !== exp_out) begin
            fail_run($sformatf("ERROR gpio_out: expected 0x%02h got 0x%02h", exp_out, gpio_out));
        end
        if (bus_data_t'(gpio_oe) !== exp_oe) begin
            fail_run($sformatf("ERROR gpio_oe: expected 0x%02h got 0x%02h", exp_oe, gpio_oe));
        end
    endtask

    task automatic check_ack_time(input bus_op_e op, input bus_data_t exp, input bus_data_t got);
        if (got !== exp) begin
            fail_run($sformatf("ERROR rbcp_ack delay on %s: expected 0x%02h got 0x%02h",
                               op.name(), exp, got));
        end
    endtask

    function automatic txn_t make_txn(bus_op_e op, bus_addr_t addr, bus_data_t data,
                                      logic [7:0] pins);
        txn_t t;
        t.op   = op;
        t.addr = addr;
        t.data = data;
        t.pins = pins;
        return t;
    endfunction

    // register map as seen from rbcp
    function automatic bus_data_t expected_read(bus_addr_t addr, logic [7:0] pins);
        bus_data_t val;
        val = '0;       // unmapped space reads zero
        if (addr >= `GPIO_BASEADDR && addr <= `GPIO_HIGHADDR) begin
            case (int'(addr - `GPIO_BASEADDR))
                0:       val = `GPIO_VERSION;
                1:       val = pins;
                2:       val = model_out;
                3:       val = model_dir;
                default: val = '0;
            endcase
        end else if (addr >= `SCRATCH_BASEADDR && addr <= `SCRATCH_HIGHADDR) begin
            val = model_scratch[int'(addr - `SCRATCH_BASEADDR)];
        end
        return val;
    endfunction

    function automatic void model_write(bus_addr_t addr, bus_data_t data);
        if (addr == `GPIO_BASEADDR + 2) begin
            model_out = data;
        end else if (addr == `GPIO_BASEADDR + 3) begin
            model_dir = data;
        end else if (addr >= `SCRATCH_BASEADDR && addr <= `SCRATCH_HIGHADDR) begin
            model_scratch[int'(addr - `SCRATCH_BASEADDR)] = data;
        end
    endfunction

    // counts cycles from the sampling edge to the ack
    task automatic wait_ack(output bus_data_t cycles, output bus_data_t rd_val);
        logic got;
        got    = 1'b0;
        cycles = '0;
        rd_val = '0;
        while (!got && cycles < 8'd8) begin
            @(negedge bus_clk);
            cycles = cycles + 1'b1;
            if (rbcp_ack) begin
                got    = 1'b1;
                rd_val = rbcp_rd;   // valid with the ack
            end
        end
        if (!got) begin
            fail_run("no rbcp_ack within 8 cycles of the request");
        end
    endtask

    task automatic run_access(input txn_t t);
        bus_data_t cycles;
        bus_data_t rd_val;
        bus_data_t exp_rd;
        @(posedge bus_clk);
        #1;
        rbcp_addr = t.addr;
        rbcp_wd   = t.data;
        gpio_in   = t.pins;
        rbcp_we   = (t.op == op_write);
        rbcp_re   = (t.op == op_read);
        exp_rd    = expected_read(t.addr, t.pins);
        @(posedge bus_clk);     // cycle 0, request sampled
        #1;
        rbcp_we = 1'b0;
        rbcp_re = 1'b0;
        wait_ack(cycles, rd_val);
        if (t.op == op_read) begin
            check_ack_time(t.op, 8'd3, cycles);
            check_rd(t.addr, exp_rd, rd_val);
        end else begin
            check_ack_time(t.op, 8'd2, cycles);
            model_write(t.addr, t.data);
            check_gpio(model_out, model_dir);
        end
        @(negedge bus_clk);
        if (rbcp_ack) begin
            fail_run("rbcp_ack stayed high for more than one cycle");
        end
    endtask

    // read request, session closes for one cycle under it
    task automatic drop_act_after_request();
        @(posedge bus_clk);
        #1;
        rbcp_addr = `SCRATCH_BASEADDR;
        rbcp_re   = 1'b1;
        @(posedge bus_clk);
        #1;
        rbcp_re  = 1'b0;
        rbcp_act = 1'b0;
        @(negedge bus_clk);
        if (rbcp_ack) begin
            fail_run($sformatf("rbcp_ack came after rbcp_act was dropped, bridge state %0d",
                               dut.i_bridge.state));
        end
        @(posedge bus_clk);     // bridge should be idle again
        #1;
        rbcp_act = 1'b1;        // back while the read would still be pending
        repeat (6) begin
            @(negedge bus_clk);
            if (rbcp_ack) begin
                fail_run($sformatf("stale rbcp_ack after rbcp_act came back, bridge state %0d",
                                   dut.i_bridge.state));
            end
        end
    endtask

    initial begin
        txn_t t;
        bus_clk       = 1'b0;
        rst_n         = 1'b0;
        rbcp_act      = 1'b0;
        rbcp_addr     = '0;
        rbcp_wd       = '0;
        rbcp_we       = 1'b0;
        rbcp_re       = 1'b0;
        gpio_in       = '0;
        model_out     = '0;
        model_dir     = 8'h0f;          // reset direction of the top level
        model_scratch = '{default: '0};
        void'($urandom(63));
        repeat (4) @(posedge bus_clk);
        #1;
        rst_n    = 1'b1;
        rbcp_act = 1'b1;
        repeat (2) @(posedge bus_clk);  // direction mask loads after reset
        #1;
        check_gpio(model_out, model_dir);

        run_access(make_txn(op_read, `GPIO_BASEADDR, 8'h00, 8'h00));
        for (int i = 0; i < 16; i++) begin
            run_access(make_txn(op_read, `SCRATCH_BASEADDR + i, 8'h00, 8'h00));
        end

        run_access(make_txn(op_write, 32'h02, 8'ha5, 8'h00));
        run_access(make_txn(op_write, 32'h03, 8'h3c, 8'h00));
        run_access(make_txn(op_read, 32'h02, 8'h00, 8'h00));
        run_access(make_txn(op_read, 32'h03, 8'h00, 8'h00));
        run_access(make_txn(op_read, 32'h01, 8'h00, 8'h5a));   // pins seen on read

        run_access(make_txn(op_write, 32'h13, 8'h77, 8'h00));
        run_access(make_txn(op_read, 32'h13, 8'h00, 8'h00));

        // holes in the map
        run_access(make_txn(op_write, 32'h2a, 8'hff, 8'h00));
        run_access(make_txn(op_write, 32'h09, 8'hff, 8'h00));
        run_access(make_txn(op_read, 32'h2a, 8'h00, 8'h00));
        run_access(make_txn(op_read, 32'h09, 8'h00, 8'h00));
        run_access(make_txn(op_read, 32'h02, 8'h00, 8'h00));

        drop_act_after_request();
        run_access(make_txn(op_write, 32'h1f, 8'hc3, 8'h00));
        run_access(make_txn(op_read, 32'h1f, 8'h00, 8'h00));

        for (int i = 0; i < NUM_RANDOM; i++) begin
            t.op   = ($urandom % 2 == 0) ? op_write : op_read;
            t.addr = 32'($urandom % 48);    // gpio, scratch and one empty window
            t.data = 8'($urandom);
            t.pins = 8'($urandom);
            run_access(t);
        end

        $display("sim passed");
        $finish;
    end

endmodule

// ==== verilog/rbcp_bus_top.sv ====
`timescale 1ns/1ps

module rbcp_bus_top (
    input  logic                    bus_clk,
    input  logic                    rst_n,
    input  logic                    rbcp_act,
    input  rbcp_bus_pkg::bus_addr_t rbcp_addr,
    input  rbcp_bus_pkg::bus_data_t rbcp_wd,
    input  logic                    rbcp_we,
    input  logic                    rbcp_re,
    input  logic [7:0]              gpio_in,
    output logic                    rbcp_ack,
    output rbcp_bus_pkg::bus_data_t rbcp_rd,
    output logic [7:0]              gpio_out,
    output logic [7:0]              gpio_oe
);
    import rbcp_bus_pkg::*;

    bus_addr_t bus_addr;        // shared strobe bus
    bus_data_t bus_wdata;
    bus_data_t gpio_rdata;
    bus_data_t scratch_rdata;
    logic      bus_wr;
    logic      bus_rd;
    logic      timer_start;
    logic      timer_done;

    rbcp_bridge_fsm i_bridge (
        .bus_clk       (bus_clk),
        .rst_n         (rst_n),
        .rbcp_act      (rbcp_act),
        .rbcp_addr     (rbcp_addr),
        .rbcp_wd       (rbcp_wd),
        .rbcp_we       (rbcp_we),
        .rbcp_re       (rbcp_re),
        .timer_done    (timer_done),
        .gpio_rdata    (gpio_rdata),
        .scratch_rdata (scratch_rdata),
        .rbcp_ack      (rbcp_ack),
        .rbcp_rd       (rbcp_rd),
        .bus_addr      (bus_addr),
        .bus_wdata     (bus_wdata),
        .bus_wr        (bus_wr),
        .bus_rd        (bus_rd),
        .timer_start   (timer_start)
    );

    bus_latency_timer i_timer (
        .bus_clk     (bus_clk),
        .rst_n       (rst_n),
        .timer_start (timer_start),
        .timer_done  (timer_done)
    );

    gpio_regs #(
        .IO_WIDTH     (8),
        .IO_DIRECTION (8'h0f)   // low nibble drives leds
    ) i_gpio (
        .bus_clk    (bus_clk),
        .rst_n      (rst_n),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_wr     (bus_wr),
        .bus_rd     (bus_rd),
        .gpio_in    (gpio_in),
        .gpio_rdata (gpio_rdata),
        .gpio_out   (gpio_out),
        .gpio_oe    (gpio_oe)
    );

    scratch_regs i_scratch (
        .bus_clk       (bus_clk),
        .rst_n         (rst_n),
        .bus_addr      (bus_addr),
        .bus_wdata     (bus_wdata),
        .bus_wr        (bus_wr),
        .bus_rd        (bus_rd),
        .scratch_rdata (scratch_rdata)
    );

endmodule

// ==== verilog/scratch_regs.sv ====
`timescale 1ns/1ps
`include "rbcp_macros.svh"

module scratch_regs (
    input  logic                    bus_clk,
    input  logic                    rst_n,
    input  rbcp_bus_pkg::bus_addr_t bus_addr,
    input  rbcp_bus_pkg::bus_data_t bus_wdata,
    input  logic                    bus_wr,
    input  logic                    bus_rd,
    output rbcp_bus_pkg::bus_data_t scratch_rdata   // held until next bus_rd
);
    import rbcp_bus_pkg::*;

    localparam int NUM_BYTES = 16;
    localparam int OFS_W     = $clog2(NUM_BYTES);

    bus_data_t        regs [NUM_BYTES];
    logic             sel;
    logic [OFS_W-1:0] offset;     // byte index in the bank

    assign sel    = addr_in_window(bus_addr, `SCRATCH_BASEADDR, `SCRATCH_HIGHADDR);
    assign offset = OFS_W'(bus_addr - `SCRATCH_BASEADDR);

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (bus_wr && sel) begin
            regs[offset] <= bus_wdata;
        end
    end

    always_ff @(posedge bus_clk) begin
        if (bus_rd) begin
            scratch_rdata <= sel ? regs[offset] : '0;   // zero keeps the or clean
        end
    end

endmodule

// ==== verilog/gpio_regs.sv ====
`timescale 1ns/1ps
`include "rbcp_macros.svh"

module gpio_regs #(
    parameter int                  IO_WIDTH     = 8,
    parameter logic [IO_WIDTH-1:0] IO_DIRECTION = '0    // 1 = output
) (
    input  logic                    bus_clk,
    input  logic                    rst_n,
    input  rbcp_bus_pkg::bus_addr_t bus_addr,
    input  rbcp_bus_pkg::bus_data_t bus_wdata,
    input  logic                    bus_wr,
    input  logic                    bus_rd,
    input  logic [IO_WIDTH-1:0]     gpio_in,
    output rbcp_bus_pkg::bus_data_t gpio_rdata,     // held until next bus_rd
    output logic [IO_WIDTH-1:0]     gpio_out,
    output logic [IO_WIDTH-1:0]     gpio_oe
);
    import rbcp_bus_pkg::*;

    localparam logic [3:0] REG_VERSION = 4'd0;
    localparam logic [3:0] REG_IN      = 4'd1;
    localparam logic [3:0] REG_OUT     = 4'd2;
    localparam logic [3:0] REG_DIR     = 4'd3;

    logic                sel;
    logic [3:0]          offset;
    logic [IO_WIDTH-1:0] in_q;      // pins sampled each cycle
    logic [IO_WIDTH-1:0] out_q;
    logic [IO_WIDTH-1:0] dir_q;
    logic                dir_init;  // reset mask loaded

    if (IO_WIDTH < 1 || IO_WIDTH > 8) begin : g_width_check
        $error("gpio_regs IO_WIDTH %0d outside 1..8", IO_WIDTH);
    end

    assign sel    = addr_in_window(bus_addr, `GPIO_BASEADDR, `GPIO_HIGHADDR);
    assign offset = 4'(bus_addr - `GPIO_BASEADDR);

    always_ff @(posedge bus_clk) begin
        in_q <= gpio_in;
    end

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            out_q    <= '0;
            dir_q    <= '0;         // all inputs while in reset
            dir_init <= 1'b0;
        end else begin
            if (!dir_init) begin
                dir_q    <= IO_DIRECTION;   // first cycle out of reset
                dir_init <= 1'b1;
            end else if (bus_wr && sel && offset == REG_DIR) begin
                dir_q <= bus_wdata[IO_WIDTH-1:0];
            end
            if (bus_wr && sel && offset == REG_OUT) begin
                out_q <= bus_wdata[IO_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge bus_clk) begin
        if (bus_rd) begin
            gpio_rdata <= '0;           // unaddressed or unused offset
            if (sel) begin
                case (offset)
                    REG_VERSION: gpio_rdata <= `GPIO_VERSION;
                    REG_IN:      gpio_rdata <= bus_data_t'(in_q);
                    REG_OUT:     gpio_rdata <= bus_data_t'(out_q);
                    REG_DIR:     gpio_rdata <= bus_data_t'(dir_q);
                    default:     gpio_rdata <= '0;
                endcase
            end
        end
    end

    assign gpio_out = out_q;
    assign gpio_oe  = dir_q;

endmodule

// ==== verilog/bus_latency_timer.sv ====
`timescale 1ns/1ps
`include "rbcp_macros.svh"

module bus_latency_timer (
    input  logic bus_clk,
    input  logic rst_n,
    input  logic timer_start,   // same cycle as bus_rd
    output logic timer_done     // one cycle, latency after start
);
    localparam int CNT_W = $clog2(`BUS_RD_LATENCY + 1);

    logic [CNT_W-1:0] cnt;      // cycles left

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (timer_start) begin
            cnt <= CNT_W'(`BUS_RD_LATENCY);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    // last count, reaches zero on the next edge
    assign timer_done = (cnt == CNT_W'(1));

    // bridge keeps one read in flight
    a_start_idle: assert property (@(posedge bus_clk) disable iff (!rst_n)
        timer_start |-> (cnt == '0))
        else $error("timer_start while count is %0d", cnt);

endmodule

// ==== verilog/rbcp_bridge_fsm.sv ====
`timescale 1ns/1ps

module rbcp_bridge_fsm (
    input  logic                    bus_clk,
    input  logic                    rst_n,
    input  logic                    rbcp_act,       // session open
    input  rbcp_bus_pkg::bus_addr_t rbcp_addr,      // valid with we/re pulse
    input  rbcp_bus_pkg::bus_data_t rbcp_wd,
    input  logic                    rbcp_we,        // one-cycle pulse
    input  logic                    rbcp_re,        // one-cycle pulse
    input  logic                    timer_done,
    input  rbcp_bus_pkg::bus_data_t gpio_rdata,     // zero when not addressed
    input  rbcp_bus_pkg::bus_data_t scratch_rdata,  // zero when not addressed
    output logic                    rbcp_ack,
    output rbcp_bus_pkg::bus_data_t rbcp_rd,
    output rbcp_bus_pkg::bus_addr_t bus_addr,
    output rbcp_bus_pkg::bus_data_t bus_wdata,
    output logic                    bus_wr,
    output logic                    bus_rd,
    output logic                    timer_start
);
    import rbcp_bus_pkg::*;
    import rbcp_bridge_pkg::*;

    bridge_state_e state;
    bridge_state_e state_nxt;
    bus_op_e       op_q;        // pending access kind
    bus_addr_t     addr_q;
    bus_data_t     wdata_q;
    bus_data_t     rdata_q;     // or of both slaves
    logic          req;

    assign req = rbcp_act && (rbcp_we || rbcp_re);

    always_comb begin
        state_nxt = state;
        case (state)
            idle: begin
                if (req) begin
                    state_nxt = rbcp_we ? wr_strobe : rd_strobe;  // we wins, flagged below
                end
            end
            wr_strobe: state_nxt = ack;
            rd_strobe: state_nxt = rd_wait;
            rd_wait: begin
                if (timer_done) begin
                    state_nxt = idle;   // ack goes out this cycle
                end
            end
            ack:       state_nxt = idle;
            default:   state_nxt = idle;
        endcase
        // session closed, drop the access silently
        if (!rbcp_act) begin
            state_nxt = idle;
        end
    end

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            state <= idle;
            op_q  <= op_write;
        end else begin
            state <= state_nxt;
            if (state == idle && req) begin
                op_q <= rbcp_we ? op_write : op_read;
            end
        end
    end

    always_ff @(posedge bus_clk) begin
        if (state == idle && req) begin
            addr_q  <= rbcp_addr;
            wdata_q <= rbcp_wd;
        end
        if (state == rd_wait) begin
            rdata_q <= gpio_rdata | scratch_rdata;  // slaves hold data after bus_rd
        end
    end

    assign bus_addr    = addr_q;
    assign bus_wdata   = wdata_q;
    assign bus_wr      = (state == wr_strobe);
    assign bus_rd      = (state == rd_strobe);
    assign timer_start = (state == rd_strobe);      // paces the read
    assign rbcp_ack    = rbcp_act &&
                         ((state == ack) || (state == rd_wait && timer_done));
    assign rbcp_rd     = (op_q == op_read) ? rdata_q : '0;   // zero on write acks

    a_we_re_excl: assert property (@(posedge bus_clk) disable iff (!rst_n)
        !(rbcp_we && rbcp_re))
        else $error("rbcp_we and rbcp_re in the same cycle");

    // requester must wait for the ack
    a_req_in_idle: assert property (@(posedge bus_clk) disable iff (!rst_n)
        (rbcp_we || rbcp_re) |-> (state == idle))
        else $error("rbcp request while bridge busy, state %s", state.name());

    a_ack_pulse: assert property (@(posedge bus_clk) disable iff (!rst_n)
        rbcp_ack |=> !rbcp_ack)
        else $error("rbcp_ack longer than one cycle");

endmodule

// ==== verilog/rbcp_bridge_pkg.sv ====
package rbcp_bridge_pkg;

    // one bus strobe and one ack per request
    typedef enum logic [2:0] {
        idle      = 3'd0,   // wait for rbcp_we / rbcp_re
        wr_strobe = 3'd1,   // bus_wr high
        rd_strobe = 3'd2,   // bus_rd and timer_start high
        rd_wait   = 3'd3,   // slave data settles, ack on timer_done
        ack       = 3'd4    // write ack
    } bridge_state_e;

endpackage

// ==== verilog/rbcp_bus_pkg.sv ====
package rbcp_bus_pkg;

    typedef logic [31:0] bus_addr_t;    // full rbcp address, one word
    typedef logic [7:0]  bus_data_t;    // rbcp moves one byte per access

    // kind of access held by the bridge
    typedef enum logic {
        op_write = 1'b0,
        op_read  = 1'b1
    } bus_op_e;

    // slave window decode, base and high both inclusive
    function automatic logic addr_in_window(
        input bus_addr_t addr,
        input bus_addr_t base,
        input bus_addr_t high
    );
        return (addr >= base) && (addr <= high);
    endfunction

endpackage

// ==== verilog/rbcp_macros.svh ====
`ifndef RBCP_MACROS_SVH
`define RBCP_MACROS_SVH

// gpio window
`define GPIO_BASEADDR    32'h0000_0000
`define GPIO_HIGHADDR    32'h0000_000f

// scratch bank window
`define SCRATCH_BASEADDR 32'h0000_0010
`define SCRATCH_HIGHADDR 32'h0000_001f

`define BUS_RD_LATENCY   2      // cycles from bus_rd to timer_done

`define GPIO_VERSION     8'h01  // read at gpio offset 0

`endif
